// File: files.f
+incdir+source
source/fetch_pkg.sv
source/instr_stream_if.sv
source/fetch_target_mux.sv
source/prefetch_buffer.sv
source/if_id_register.sv
source/fetch_stage.sv
dv/instr_mem_model.sv
dv/tb_fetch_stage.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the fetch stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_fetch_stage -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_fetch_stage)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

// File: dv/tb_fetch_stage.sv
/* Fetch stage testbench
   Boot, redirects, back-pressure, halt and bus errors checked against a
   reference of the redirect and memory rules */

module tb_fetch_stage;

  localparam int unsigned TEST_CNT       = 6;
  localparam int unsigned TIMEOUT_CYCLES = 200 * TEST_CNT + 200;  // Plus reset margin
  localparam logic [31:0] ERR_LO         = 32'h0000_1000;
  localparam logic [31:0] ERR_HI         = 32'h0000_1100;
  localparam logic [31:0] DATA_KEY       = 32'h5a5a_a5a5;

  logic               clk, rst_n, pc_set_i, halt_if_i, id_ready_i;
  fetch_pkg::pc_mux_e pc_mux_i;
  fetch_pkg::addr_t   boot_addr_i, jump_target_i, branch_target_i, mepc_i;
  fetch_pkg::mtvec_t  mtvec_addr_i;
  fetch_pkg::irq_id_t irq_id_i;
  logic               instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  fetch_pkg::addr_t   instr_addr_o, if_id_pc_o, pc_if_o;
  fetch_pkg::instr_t  instr_rdata_i, if_id_instr_o;
  logic               if_id_valid_o, if_id_err_o, csr_mtvec_init_o, if_busy_o;
  logic [7:0]         pending;          // Model's unanswered reads

  int unsigned        errors = 0;
  int unsigned        checks = 0;
  int unsigned        accepted = 0;     // Outputs taken by decode
  int unsigned        cycle_cnt = 0;
  string              test_name = "reset";
  logic               booted = 1'b0;
  logic               hold_q = 1'b0;    // IF/ID must hold at this edge
  logic               halt_q = 1'b0;    // No new instruction may appear
  fetch_pkg::addr_t   exp_pc, held_pc;
  fetch_pkg::instr_t  held_instr;
  logic               held_err;
  fetch_pkg::addr_t   head_pc_q;        // Stream head at the last edge
  logic               req_wait_q = 1'b0;  // Request still waiting for its grant
  fetch_pkg::addr_t   req_addr_q;

  fetch_stage uut (.*);

  instr_mem_model #(.ERR_LO(ERR_LO), .ERR_HI(ERR_HI), .DATA_KEY(DATA_KEY)) mem_i (
    .clk(clk), .rst_n(rst_n), .req_i(instr_req_o), .addr_i(instr_addr_o),
    .gnt_o(instr_gnt_i), .rvalid_o(instr_rvalid_i), .rdata_o(instr_rdata_i),
    .err_o(instr_err_i), .pending_o(pending)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic fetch_pkg::addr_t redirect_ref(input fetch_pkg::pc_mux_e src,
      input fetch_pkg::addr_t boot, jump, branch, mepc,
      input fetch_pkg::mtvec_t mtvec, input fetch_pkg::irq_id_t irq);
    fetch_pkg::addr_t t;
    case (src)
      fetch_pkg::PC_JUMP:     t = jump;
      fetch_pkg::PC_BRANCH:   t = branch;
      fetch_pkg::PC_MRET:     t = mepc;
      fetch_pkg::PC_TRAP_EXC: t = {mtvec, 7'b0};        // Base, seven zero bits
      fetch_pkg::PC_TRAP_IRQ: t = {mtvec, irq, 2'b00};  // One word per id
      default:                t = boot;
    endcase
    t[1:0] = 2'b00;  // Word aligned
    return t;
  endfunction

  function automatic fetch_pkg::instr_t instr_ref(input fetch_pkg::addr_t pc);
    return pc ^ DATA_KEY;
  endfunction

  function automatic logic err_ref(input fetch_pkg::addr_t pc);
    return (pc >= ERR_LO) && (pc < ERR_HI);
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp, act);
    errors = errors + 1;
    $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
  endtask

  task automatic report_problem(input string msg);
    errors = errors + 1;
    $display("ERROR in %s: %s", test_name, msg);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checker
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      checks = checks + 1;
      if (csr_mtvec_init_o !== (pc_set_i && pc_mux_i == fetch_pkg::PC_BOOT)) begin
        report_mismatch("mtvec_init", 32'(pc_set_i && pc_mux_i == fetch_pkg::PC_BOOT),
                        32'(csr_mtvec_init_o));
      end
      if (!booted && (instr_req_o || if_busy_o || if_id_valid_o)) begin
        report_problem("fetch activity before the first redirect");
      end
      if (req_wait_q && (!instr_req_o || instr_addr_o !== req_addr_q)) begin
        report_problem("instruction request dropped or moved before its grant");
      end
      if (pending != 0 && !if_busy_o) begin
        report_problem("if_busy_o low while a granted read is unanswered");
      end
      if (hold_q && (!if_id_valid_o || if_id_pc_o !== held_pc ||
          if_id_instr_o !== held_instr || if_id_err_o !== held_err)) begin
        report_problem("IF/ID output changed while decode was not ready");
      end
      if (halt_q && if_id_valid_o) begin
        report_problem("new instruction entered IF/ID during halt");
      end
      // Fresh IF/ID entry came from the head offered at the last edge
      if (if_id_valid_o && !hold_q && head_pc_q !== exp_pc) begin
        report_mismatch("pc_if", exp_pc, head_pc_q);
      end
      if (if_id_valid_o && id_ready_i) begin  // Accepted by decode
        if (if_id_pc_o !== exp_pc) report_mismatch("pc", exp_pc, if_id_pc_o);
        if (if_id_instr_o !== instr_ref(exp_pc)) begin
          report_mismatch("instr", instr_ref(exp_pc), if_id_instr_o);
        end
        if (if_id_err_o !== err_ref(exp_pc)) begin
          report_mismatch("err", 32'(err_ref(exp_pc)), 32'(if_id_err_o));
        end
        exp_pc   = exp_pc + 4;
        accepted = accepted + 1;
      end
      if (pc_set_i) begin  // New stream starts at the target
        exp_pc = redirect_ref(pc_mux_i, boot_addr_i, jump_target_i, branch_target_i,
                              mepc_i, mtvec_addr_i, irq_id_i);
        booted = 1'b1;
      end
      hold_q     = if_id_valid_o && !id_ready_i && !pc_set_i;
      halt_q     = halt_if_i && !hold_q;
      held_pc    = if_id_pc_o;
      held_instr = if_id_instr_o;
      held_err   = if_id_err_o;
      head_pc_q  = pc_if_o;
      req_wait_q = instr_req_o && !instr_gnt_i;
      req_addr_q = instr_addr_o;
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles in test %s", cycle_cnt, test_name);
      $display("Testbench failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic wait_accepted(input int unsigned n);
    int unsigned target;
    target = accepted + n;
    while (accepted < target) @(posedge clk);
  endtask

  task automatic issue_redirect(input fetch_pkg::pc_mux_e src);
    @(posedge clk);
    pc_set_i        <= 1'b1;
    pc_mux_i        <= src;
    jump_target_i   <= 32'h0000_0e00 + ($urandom % 32'h400);  // Unaligned too
    branch_target_i <= 32'h0000_0e00 + ($urandom % 32'h400);
    mepc_i          <= 32'h0000_0e00 + ($urandom % 32'h400);
    mtvec_addr_i    <= 25'(32'h20 + ($urandom % 3));          // 0x1000 to 0x1100
    irq_id_i        <= 5'($urandom);
    @(posedge clk);
    pc_set_i <= 1'b0;
  endtask

  task automatic jump_to(input fetch_pkg::addr_t target);
    @(posedge clk);
    pc_set_i      <= 1'b1;
    pc_mux_i      <= fetch_pkg::PC_JUMP;
    jump_target_i <= target;
    @(posedge clk);
    pc_set_i <= 1'b0;
  endtask

  initial begin
    void'($urandom(32'hec35));
    rst_n           = 1'b0;
    pc_set_i        = 1'b0;
    pc_mux_i        = fetch_pkg::PC_BOOT;
    boot_addr_i     = 32'h0000_0fe2;   // Unaligned, runs into the error window
    jump_target_i   = '0;
    branch_target_i = '0;
    mepc_i          = '0;
    mtvec_addr_i    = '0;
    irq_id_i        = '0;
    halt_if_i       = 1'b0;
    id_ready_i      = 1'b1;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    test_name = "idle";              // Bus must stay quiet
    repeat (8) @(posedge clk);

    test_name = "boot";
    issue_redirect(fetch_pkg::PC_BOOT);
    wait_accepted(16);

    test_name = "redirect";          // Random sources and random gaps
    repeat (25) begin
      repeat ($urandom % 6) @(posedge clk);
      issue_redirect(fetch_pkg::pc_mux_e'(3'(1 + ($urandom % 5))));
    end
    wait_accepted(6);

    test_name = "back_pressure";
    repeat (150) begin
      @(posedge clk);
      id_ready_i <= 1'($urandom);
    end
    @(posedge clk);
    id_ready_i <= 1'b1;
    wait_accepted(4);

    test_name = "halt";
    repeat (4) begin
      @(posedge clk);
      halt_if_i <= 1'b1;
      repeat (20) begin
        @(posedge clk);
        id_ready_i <= 1'($urandom);
      end
      halt_if_i  <= 1'b0;
      id_ready_i <= 1'b1;
      wait_accepted(3);              // Resumes at the next address
    end

    test_name = "bus_error";         // Crosses both window edges
    jump_to(32'h0000_0fe8);
    wait_accepted(72);

    repeat (10) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: dv/instr_mem_model.sv
/* Instruction memory model
   Random grant stalls, in-order responses after 1 to 4 cycles, data and
   error flag derived from the address */

module instr_mem_model #(
  parameter logic [31:0] ERR_LO   = 32'h0000_1000,  // Error window, inclusive
  parameter logic [31:0] ERR_HI   = 32'h0000_1100,  // Error window, exclusive
  parameter logic [31:0] DATA_KEY = 32'h5a5a_a5a5   // rdata is addr XOR key
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o,
  output logic [7:0]  pending_o  // Granted, not yet answered
);

  logic        stall_q;     // Grant withheld this cycle
  logic        pop;         // Head response goes out
  logic [31:0] q_addr [$];  // Granted reads, oldest first
  int unsigned q_due  [$];  // Response cycle per read
  int unsigned cycle;
  int unsigned due;

  assign gnt_o = req_i & ~stall_q;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stall_q   <= 1'b0;
      rvalid_o  <= 1'b0;
      rdata_o   <= '0;
      err_o     <= 1'b0;
      pending_o <= '0;
      q_addr.delete();
      q_due.delete();
      cycle = 0;
    end else begin
      cycle   = cycle + 1;
      stall_q <= ($urandom % 4) == 0;   // Roughly one stall in four
      if (req_i && gnt_o) begin
        due = cycle + ($urandom % 4);   // Latency 1 to 4
        if (q_due.size() != 0 && due < q_due[$]) due = q_due[$];  // In order
        q_addr.push_back(addr_i);
        q_due.push_back(due);
      end
      pop = (q_due.size() != 0) && (q_due[0] <= cycle);
      rvalid_o <= pop;
      if (pop) begin
        rdata_o <= q_addr[0] ^ DATA_KEY;
        err_o   <= (q_addr[0] >= ERR_LO) && (q_addr[0] < ERR_HI);
        void'(q_addr.pop_front());
        void'(q_due.pop_front());
      end
      pending_o <= 8'(q_addr.size()) + 8'(pop);  // Queue plus the one on rvalid
    end
  end

endmodule

// File: source/fetch_stage.sv
/* Instruction fetch stage
   Redirect target select, prefetch buffer and IF/ID register */

module fetch_stage (
  input  logic                clk,
  input  logic                rst_n,

  // Redirect from the controller
  input  logic                pc_set_i,
  input  fetch_pkg::pc_mux_e  pc_mux_i,
  input  fetch_pkg::addr_t    boot_addr_i,
  input  fetch_pkg::addr_t    jump_target_i,
  input  fetch_pkg::addr_t    branch_target_i,
  input  fetch_pkg::addr_t    mepc_i,
  input  fetch_pkg::mtvec_t   mtvec_addr_i,
  input  fetch_pkg::irq_id_t  irq_id_i,

  // Stage control
  input  logic                halt_if_i,
  input  logic                id_ready_i,

  // Instruction bus
  output logic                instr_req_o,
  output fetch_pkg::addr_t    instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  fetch_pkg::instr_t   instr_rdata_i,
  input  logic                instr_err_i,

  // IF/ID pipeline
  output logic                if_id_valid_o,
  output fetch_pkg::instr_t   if_id_instr_o,
  output fetch_pkg::addr_t    if_id_pc_o,
  output logic                if_id_err_o,

  // Status
  output fetch_pkg::addr_t    pc_if_o,           // Head of the stream
  output logic                csr_mtvec_init_o,
  output logic                if_busy_o
);

  logic             pc_set;         // Redirect toward the buffer
  fetch_pkg::addr_t redirect_addr;

  instr_stream_if instr_stream ();  // Buffer to IF/ID

  //////////////////////////////////////////////////////////////////////
  // Redirect target
  //////////////////////////////////////////////////////////////////////

  fetch_target_mux target_mux_i (
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .pc_set_o         (pc_set),
    .redirect_addr_o  (redirect_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Prefetch and pipeline register
  //////////////////////////////////////////////////////////////////////

  prefetch_buffer prefetch_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_set_i        (pc_set),
    .redirect_addr_i (redirect_addr),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_err_i     (instr_err_i),
    .busy_o          (if_busy_o),
    .stream          (instr_stream.source)
  );

  if_id_register if_id_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .halt_if_i     (halt_if_i),
    .id_ready_i    (id_ready_i),
    .stream        (instr_stream.sink),
    .if_id_valid_o (if_id_valid_o),
    .if_id_instr_o (if_id_instr_o),
    .if_id_pc_o    (if_id_pc_o),
    .if_id_err_o   (if_id_err_o)
  );

  assign pc_if_o = instr_stream.addr;  // pc of the instruction offered to IF/ID

endmodule

// File: source/if_id_register.sv
/* IF/ID pipeline register
   Takes one instruction per edge from the stream, holds under back-pressure */

module if_id_register (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              pc_set_i,       // Redirect, drop everything
  input  logic              halt_if_i,      // Controller halt
  input  logic              id_ready_i,     // Decode can take an instruction
  instr_stream_if.sink      stream,
  output logic              if_id_valid_o,
  output fetch_pkg::instr_t if_id_instr_o,
  output fetch_pkg::addr_t  if_id_pc_o,
  output logic              if_id_err_o
);

  logic xfer;  // Instruction moves into the register

  //////////////////////////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////////////////////////

  // Forced high on a redirect so the stale head drains
  assign stream.ready = pc_set_i | (id_ready_i & ~halt_if_i);

  assign xfer = stream.valid & stream.ready & ~pc_set_i;

  //////////////////////////////////////////////////////////////////////
  // Register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_valid_o <= 1'b0;
    end else if (pc_set_i) begin
      if_id_valid_o <= 1'b0;       // Flushed by the redirect
    end else if (xfer) begin
      if_id_valid_o <= 1'b1;
    end else if (id_ready_i) begin
      if_id_valid_o <= 1'b0;       // Consumed, nothing new
    end
  end

  // Payload follows the transfer only
  always_ff @(posedge clk) begin
    if (xfer) begin
      if_id_instr_o <= stream.instr;
      if_id_pc_o    <= stream.addr;
      if_id_err_o   <= stream.err;
    end
  end

endmodule

// File: source/prefetch_buffer.sv
/* Prefetch buffer
   Issues word reads on the req/gnt/rvalid bus, buffers the responses and
   drops the ones made stale by a redirect */

`include "fetch_macros.svh"

module prefetch_buffer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              pc_set_i,         // Redirect this cycle
  input  fetch_pkg::addr_t  redirect_addr_i,  // Redirect target
  output logic              instr_req_o,
  output fetch_pkg::addr_t  instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  fetch_pkg::instr_t instr_rdata_i,
  input  logic              instr_err_i,
  output logic              busy_o,           // Reads in flight or request up
  instr_stream_if.source    stream
);

  localparam int DEPTH = `FETCH_DEPTH;
  localparam int CNT_W = $clog2(DEPTH + 1);              // Counts 0..DEPTH
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  fetch_pkg::pb_state_e state_q;
  fetch_pkg::pb_state_e state_n;
  fetch_pkg::addr_t     fetch_addr_q;  // Address on the bus, next to request
  fetch_pkg::addr_t     fetch_addr_n;
  fetch_pkg::addr_t     rsp_addr_q;    // pc of next response that is kept
  fetch_pkg::addr_t     rsp_addr_n;
  logic [CNT_W-1:0]     outst_q;       // Granted, not yet answered
  logic [CNT_W-1:0]     outst_n;
  logic [CNT_W-1:0]     disc_q;        // In flight across a redirect
  logic [CNT_W-1:0]     disc_n;
  logic [CNT_W-1:0]     fill_q;        // Buffered responses
  logic [CNT_W-1:0]     fill_n;
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;

  // Response storage
  fetch_pkg::instr_t    fifo_instr [DEPTH];
  fetch_pkg::addr_t     fifo_addr  [DEPTH];
  logic [DEPTH-1:0]     fifo_err;

  logic gnt_fire;   // Request accepted
  logic flush_gnt;  // Stale request accepted in PB_FLUSH
  logic rsp_drop;   // Response to discard
  logic rsp_keep;   // Response for the current stream
  logic push;
  logic pop;
  logic room;       // Free slot for one more read

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus side
  //////////////////////////////////////////////////////////////////////

  // Sum only grows on a grant, so req never drops before gnt
  assign room        = (int'(outst_q) + int'(fill_q)) < DEPTH;
  assign instr_req_o = (state_q != fetch_pkg::PB_IDLE) & room;
  assign instr_addr_o = fetch_addr_q;   // Held until granted
  assign busy_o      = instr_req_o | (outst_q != '0);

  assign gnt_fire  = instr_req_o & instr_gnt_i;
  assign flush_gnt = gnt_fire & (state_q == fetch_pkg::PB_FLUSH);
  assign rsp_drop  = instr_rvalid_i & (disc_q != '0);
  assign rsp_keep  = instr_rvalid_i & (disc_q == '0);

  //////////////////////////////////////////////////////////////////////
  // Stream side
  //////////////////////////////////////////////////////////////////////

  assign stream.valid = (fill_q != '0);
  assign stream.instr = fifo_instr[rd_ptr_q];
  assign stream.addr  = fifo_addr[rd_ptr_q];
  assign stream.err   = fifo_err[rd_ptr_q];

  assign pop  = stream.valid & stream.ready;
  assign push = rsp_keep & ~pc_set_i;   // Redirect empties the FIFO anyway

  // Counters
  always_comb begin
    outst_n = outst_q + CNT_W'(gnt_fire) - CNT_W'(instr_rvalid_i);
    if (pc_set_i) begin
      disc_n = outst_n;                 // Everything in flight is stale
      fill_n = '0;
    end else begin
      disc_n = disc_q - CNT_W'(rsp_drop) + CNT_W'(flush_gnt);
      fill_n = fill_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // FSM and addresses
  always_comb begin
    state_n      = state_q;
    fetch_addr_n = fetch_addr_q;
    rsp_addr_n   = rsp_addr_q;
    if (pc_set_i) begin
      rsp_addr_n = redirect_addr_i;     // First kept response is the target
    end else if (push) begin
      rsp_addr_n = rsp_addr_q + fetch_pkg::addr_t'(4);
    end

    unique case (state_q)
      fetch_pkg::PB_IDLE: begin
        if (pc_set_i) begin
          state_n      = fetch_pkg::PB_FETCH;
          fetch_addr_n = redirect_addr_i;
        end
      end
      fetch_pkg::PB_FETCH: begin
        if (pc_set_i) begin
          if (instr_req_o && !instr_gnt_i) begin
            state_n = fetch_pkg::PB_FLUSH;  // Old address must stay on bus
          end else begin
            fetch_addr_n = redirect_addr_i;
          end
        end else if (gnt_fire) begin
          fetch_addr_n = fetch_addr_q + fetch_pkg::addr_t'(4);
        end
      end
      fetch_pkg::PB_FLUSH: begin
        if (gnt_fire) begin
          state_n      = fetch_pkg::PB_FETCH;
          // Target waits in rsp_addr_q meanwhile
          fetch_addr_n = pc_set_i ? redirect_addr_i : rsp_addr_q;
        end
      end
      default: state_n = fetch_pkg::PB_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= fetch_pkg::PB_IDLE;
      fetch_addr_q <= '0;
      rsp_addr_q   <= '0;
      outst_q      <= '0;
      disc_q       <= '0;
      fill_q       <= '0;
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
    end else begin
      state_q      <= state_n;
      fetch_addr_q <= fetch_addr_n;
      rsp_addr_q   <= rsp_addr_n;
      outst_q      <= outst_n;
      disc_q       <= disc_n;
      fill_q       <= fill_n;
      if (pc_set_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
      end else begin
        if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
        if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
    end
  end

  // Response payload
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_instr[wr_ptr_q] <= instr_rdata_i;
      fifo_addr[wr_ptr_q]  <= rsp_addr_q;
      fifo_err[wr_ptr_q]   <= instr_err_i;
    end
  end

endmodule

// File: source/fetch_target_mux.sv
/* Fetch target mux
   Decodes the redirect source into a word-aligned address, flags boot */

`include "fetch_macros.svh"

module fetch_target_mux (
  input  logic                pc_set_i,         // Redirect request
  input  fetch_pkg::pc_mux_e  pc_mux_i,         // Redirect source
  input  fetch_pkg::addr_t    boot_addr_i,
  input  fetch_pkg::addr_t    jump_target_i,
  input  fetch_pkg::addr_t    branch_target_i,
  input  fetch_pkg::addr_t    mepc_i,
  input  fetch_pkg::mtvec_t   mtvec_addr_i,     // Trap base, upper bits
  input  fetch_pkg::irq_id_t  irq_id_i,         // Vector slot for interrupts
  output logic                pc_set_o,         // Redirect toward the buffer
  output fetch_pkg::addr_t    redirect_addr_o,  // Always word aligned
  output logic                csr_mtvec_init_o  // mtvec init on boot
);

  // Bits below the mtvec base in an exception target
  localparam int EXC_PAD_W = `FETCH_ADDR_W - `FETCH_MTVEC_W;

  fetch_pkg::addr_t target;  // Selected target before alignment

  //////////////////////////////////////////////////////////////////////
  // Source select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    target = boot_addr_i;  // Unused encodings fall back to boot
    unique case (pc_mux_i)
      fetch_pkg::PC_BOOT:     target = boot_addr_i;
      fetch_pkg::PC_JUMP:     target = jump_target_i;
      fetch_pkg::PC_BRANCH:   target = branch_target_i;
      fetch_pkg::PC_MRET:     target = mepc_i;  // Back to trapped pc
      fetch_pkg::PC_TRAP_EXC: target = {mtvec_addr_i, {EXC_PAD_W{1'b0}}};
      // Vectored, one word per interrupt id
      fetch_pkg::PC_TRAP_IRQ: target = {mtvec_addr_i, irq_id_i, 2'b00};
      default:                target = boot_addr_i;
    endcase
  end

  // Word alignment for every source
  assign redirect_addr_o = {target[`FETCH_ADDR_W-1:2], 2'b00};

  assign pc_set_o = pc_set_i;  // Same-cycle redirect

  // CSR file loads mtvec when booting
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == fetch_pkg::PC_BOOT);

endmodule

// File: source/instr_stream_if.sv
/* Instruction stream
   Carries fetched words from the prefetch buffer to the IF/ID register */

interface instr_stream_if;

  logic              valid;  // Head entry present
  logic              ready;  // Consumer takes the head
  fetch_pkg::instr_t instr;  // Instruction word
  fetch_pkg::addr_t  addr;   // Its pc
  logic              err;    // Bus error on this fetch

  // Prefetch buffer side
  modport source (
    output valid, instr, addr, err,
    input  ready
  );

  // IF/ID register side
  modport sink (
    input  valid, instr, addr, err,
    output ready
  );

endinterface

// File: source/fetch_pkg.sv
/* Fetch stage types
   Address, instruction and trap vector vectors plus the FSM encodings */

`include "fetch_macros.svh"

package fetch_pkg;

  // Word-sized vectors
  typedef logic [`FETCH_ADDR_W-1:0]   addr_t;    // Fetch address
  typedef logic [`FETCH_ADDR_W-1:0]   instr_t;   // Raw 32-bit instruction

  // Trap vector fields
  typedef logic [`FETCH_MTVEC_W-1:0]  mtvec_t;   // mtvec base
  typedef logic [`FETCH_IRQ_ID_W-1:0] irq_id_t;  // Interrupt id

  // Redirect source from the controller
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,  // Boot address
    PC_JUMP     = 3'd1,  // Jump target from ID
    PC_BRANCH   = 3'd2,  // Taken branch from EX
    PC_MRET     = 3'd3,  // Return from trap
    PC_TRAP_EXC = 3'd4,  // Exception, mtvec base
    PC_TRAP_IRQ = 3'd5   // Vectored interrupt
  } pc_mux_e;

  // Prefetch buffer FSM
  typedef enum logic [1:0] {
    PB_IDLE  = 2'd0,     // Out of reset, waits for first redirect
    PB_FETCH = 2'd1,     // Sequential fetching
    PB_FLUSH = 2'd2      // Stale request still waits for its grant
  } pb_state_e;

endpackage

// File: source/fetch_macros.svh
/* Fetch stage parameters
   Widths of the fetch address, trap vector fields and prefetch depth */

`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Address and word widths
//////////////////////////////////////////////////////////////////////

`define FETCH_ADDR_W 32    // Fetch address and instruction word width

//////////////////////////////////////////////////////////////////////
// Prefetch buffer
//////////////////////////////////////////////////////////////////////

// Slots shared by reads in flight and buffered responses
`define FETCH_DEPTH 2

//////////////////////////////////////////////////////////////////////
// Trap vector layout
//////////////////////////////////////////////////////////////////////

`define FETCH_MTVEC_W  25  // mtvec base, upper address bits
`define FETCH_IRQ_ID_W 5   // Interrupt id, selects the vector slot

`endif
